//--- source/rv32i_pkg.sv
package rv32i_pkg;

    // data path width and byte lanes per word
    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = XLEN / 8;

    // funct3 of the LOAD opcode
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // funct3 of the STORE opcode
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // one funct3 field, read as a load or a store type
    // depending on the opcode of the operation
    typedef union packed {
        load_funct3_t  load;
        store_funct3_t store;
    } mem_funct3_u;

endpackage : rv32i_pkg

//--- source/lsq_pkg.sv
package lsq_pkg;

    // queue entries held in order
    localparam int LSQ_DEPTH = 4;

    // result tag, sized for an 8-entry rob
    localparam int TAG_WIDTH = 3;

    // head/tail pointer and occupancy widths
    localparam int PTR_WIDTH = $clog2(LSQ_DEPTH);
    localparam int CNT_WIDTH = $clog2(LSQ_DEPTH + 1);

endpackage : lsq_pkg

//--- source/lsq_entry_if.sv
`timescale 1ns/10ps

interface lsq_entry_if;
    import rv32i_pkg::*;
    import lsq_pkg::*;

    // oldest queued operation
    logic                 valid;
    logic                 is_store;
    mem_funct3_u          funct3;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      wdata;
    logic [TAG_WIDTH-1:0] tag;

    // one-cycle pulse, head retires on this edge
    logic                 pop;

    modport fifo (
        output valid, is_store, funct3, addr, wdata, tag,
        input  pop
    );

    modport ctrl (
        input  valid, is_store, funct3, addr, wdata, tag,
        output pop
    );

endinterface : lsq_entry_if

//--- source/lsq_fifo.sv
`timescale 1ns/10ps

module lsq_fifo (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          req_i,
    output logic                          ack_o,
    input  logic                          is_store_i,
    input  rv32i_pkg::mem_funct3_u        funct3_i,
    input  logic [rv32i_pkg::XLEN-1:0]    addr_i,
    input  logic [rv32i_pkg::XLEN-1:0]    wdata_i,
    input  logic [lsq_pkg::TAG_WIDTH-1:0] tag_i,
    lsq_entry_if.fifo                     head
);
    import rv32i_pkg::*;
    import lsq_pkg::*;

    // entry storage
    logic                 is_store_mem [LSQ_DEPTH];
    mem_funct3_u          funct3_mem   [LSQ_DEPTH];
    logic [XLEN-1:0]      addr_mem     [LSQ_DEPTH];
    logic [XLEN-1:0]      wdata_mem    [LSQ_DEPTH];
    logic [TAG_WIDTH-1:0] tag_mem      [LSQ_DEPTH];

    logic [PTR_WIDTH-1:0] head_ptr;
    logic [PTR_WIDTH-1:0] tail_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 full;
    logic                 push;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(LSQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_WIDTH'(LSQ_DEPTH));

    // accept only on a fresh request with room left
    assign push = req_i & ~ack_o & ~full;

    // four-phase ack, a full queue just delays it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else if (push) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (head.pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            // push and pop together leave the count alone
            case ({push, head.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            is_store_mem[tail_ptr] <= is_store_i;
            funct3_mem[tail_ptr]   <= funct3_i;
            addr_mem[tail_ptr]     <= addr_i;
            wdata_mem[tail_ptr]    <= wdata_i;
            tag_mem[tail_ptr]      <= tag_i;
        end
    end

    // oldest entry goes to the memory controller
    assign head.valid    = (count != '0);
    assign head.is_store = is_store_mem[head_ptr];
    assign head.funct3   = funct3_mem[head_ptr];
    assign head.addr     = addr_mem[head_ptr];
    assign head.wdata    = wdata_mem[head_ptr];
    assign head.tag      = tag_mem[head_ptr];

endmodule : lsq_fifo

//--- source/data_mem_ctrl.sv
`timescale 1ns/10ps

module data_mem_ctrl (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    lsq_entry_if.ctrl                            head,
    output logic                                 data_read_o,
    output logic                                 data_write_o,
    output logic [rv32i_pkg::BYTES_PER_WORD-1:0] data_mbe_o,
    output logic [rv32i_pkg::XLEN-1:0]           data_mem_address_o,
    output logic [rv32i_pkg::XLEN-1:0]           data_mem_wdata_o,
    input  logic                                 data_mem_resp_i,
    output logic                                 load_done_o,
    output rv32i_pkg::load_funct3_t              load_type_o,
    output logic [1:0]                           load_offset_o,
    output logic [lsq_pkg::TAG_WIDTH-1:0]        load_tag_o
);
    import rv32i_pkg::*;
    import lsq_pkg::*;

    logic [1:0]                offset;
    logic [BYTES_PER_WORD-1:0] mbe_next;
    logic                      busy;
    logic                      issue;

    // load context kept for the response
    load_funct3_t              load_type_q;
    logic [1:0]                offset_q;
    logic [TAG_WIDTH-1:0]      tag_q;

    assign offset = head.addr[1:0];

    // a raised strobe is the access state
    assign busy  = data_read_o | data_write_o;
    assign issue = head.valid & ~busy;

    // byte enables from the store view of funct3
    always_comb begin
        mbe_next = '0;
        if (head.is_store) begin
            case (head.funct3.store)
                sw:      mbe_next = 4'b1111;
                sh:      mbe_next = 4'b0011 << offset;
                sb:      mbe_next = 4'b0001 << offset;
                default: mbe_next = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_read_o  <= 1'b0;
            data_write_o <= 1'b0;
            data_mbe_o   <= '0;
        end else if (issue) begin
            data_read_o  <= ~head.is_store;
            data_write_o <= head.is_store;
            data_mbe_o   <= mbe_next;
        end else if (busy && data_mem_resp_i) begin
            // back to idle for at least one cycle
            data_read_o  <= 1'b0;
            data_write_o <= 1'b0;
            data_mbe_o   <= '0;
        end
    end

    // port fields stay put until the response
    always_ff @(posedge clk) begin
        if (issue) begin
            data_mem_address_o <= {head.addr[XLEN-1:2], 2'b00};
            data_mem_wdata_o   <= head.wdata << {offset, 3'b000};
            load_type_q        <= head.funct3.load;
            offset_q           <= offset;
            tag_q              <= head.tag;
        end
    end

    // retire the head on the response edge
    assign head.pop = busy & data_mem_resp_i;

    assign load_done_o   = data_read_o & data_mem_resp_i;
    assign load_type_o   = load_type_q;
    assign load_offset_o = offset_q;
    assign load_tag_o    = tag_q;

endmodule : data_mem_ctrl

//--- source/load_formatter.sv
`timescale 1ns/10ps

module load_formatter (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          load_done_i,
    input  rv32i_pkg::load_funct3_t       load_type_i,
    input  logic [1:0]                    load_offset_i,
    input  logic [lsq_pkg::TAG_WIDTH-1:0] load_tag_i,
    input  logic [rv32i_pkg::XLEN-1:0]    data_mem_rdata_i,
    output logic                          result_valid_o,
    output logic [lsq_pkg::TAG_WIDTH-1:0] result_tag_o,
    output logic [rv32i_pkg::XLEN-1:0]    result_data_o
);
    import rv32i_pkg::*;

    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [XLEN-1:0] formatted;

    // addressed lanes, halfwords only at offset 0 or 2
    assign byte_lane = data_mem_rdata_i[{load_offset_i, 3'b000} +: 8];
    assign half_lane = data_mem_rdata_i[{load_offset_i[1], 4'b0000} +: 16];

    always_comb begin
        case (load_type_i)
            lb:      formatted = {{(XLEN-8){byte_lane[7]}}, byte_lane};
            lbu:     formatted = {{(XLEN-8){1'b0}}, byte_lane};
            lh:      formatted = {{(XLEN-16){half_lane[15]}}, half_lane};
            lhu:     formatted = {{(XLEN-16){1'b0}}, half_lane};
            default: formatted = data_mem_rdata_i;
        endcase
    end

    // single-cycle result strobe
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= load_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done_i) begin
            result_data_o <= formatted;
            result_tag_o  <= load_tag_i;
        end
    end

endmodule : load_formatter

//--- source/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic                                 clk,
    input  logic                                 arst_n_i,

    // four-phase intake
    input  logic                                 req_i,
    output logic                                 ack_o,
    input  logic                                 is_store_i,
    input  rv32i_pkg::mem_funct3_u               funct3_i,
    input  logic [rv32i_pkg::XLEN-1:0]           addr_i,
    input  logic [rv32i_pkg::XLEN-1:0]           wdata_i,
    input  logic [lsq_pkg::TAG_WIDTH-1:0]        tag_i,

    // data memory port
    output logic                                 data_read_o,
    output logic                                 data_write_o,
    output logic [rv32i_pkg::BYTES_PER_WORD-1:0] data_mbe_o,
    output logic [rv32i_pkg::XLEN-1:0]           data_mem_address_o,
    output logic [rv32i_pkg::XLEN-1:0]           data_mem_wdata_o,
    input  logic [rv32i_pkg::XLEN-1:0]           data_mem_rdata_i,
    input  logic                                 data_mem_resp_i,

    // load results
    output logic                                 result_valid_o,
    output logic [lsq_pkg::TAG_WIDTH-1:0]        result_tag_o,
    output logic [rv32i_pkg::XLEN-1:0]           result_data_o
);
    import rv32i_pkg::*;
    import lsq_pkg::*;

    logic                 load_done;
    load_funct3_t         load_type;
    logic [1:0]           load_offset;
    logic [TAG_WIDTH-1:0] load_tag;

    lsq_entry_if head_if ();

    lsq_fifo u_lsq_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .ack_o      (ack_o),
        .is_store_i (is_store_i),
        .funct3_i   (funct3_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .tag_i      (tag_i),
        .head       (head_if.fifo)
    );

    data_mem_ctrl u_data_mem_ctrl (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .head               (head_if.ctrl),
        .data_read_o        (data_read_o),
        .data_write_o       (data_write_o),
        .data_mbe_o         (data_mbe_o),
        .data_mem_address_o (data_mem_address_o),
        .data_mem_wdata_o   (data_mem_wdata_o),
        .data_mem_resp_i    (data_mem_resp_i),
        .load_done_o        (load_done),
        .load_type_o        (load_type),
        .load_offset_o      (load_offset),
        .load_tag_o         (load_tag)
    );

    load_formatter u_load_formatter (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .load_done_i      (load_done),
        .load_type_i      (load_type),
        .load_offset_i    (load_offset),
        .load_tag_i       (load_tag),
        .data_mem_rdata_i (data_mem_rdata_i),
        .result_valid_o   (result_valid_o),
        .result_tag_o     (result_tag_o),
        .result_data_o    (result_data_o)
    );

endmodule : lsu_top

//--- tests/lsu_sva.sv
`timescale 1ns/10ps

module lsu_sva (
    input logic                                 clk,
    input logic                                 arst_n_i,
    input logic                                 req_i,
    input logic                                 ack_o,
    input logic                                 data_read_o,
    input logic                                 data_write_o,
    input logic [rv32i_pkg::BYTES_PER_WORD-1:0] data_mbe_o,
    input logic [rv32i_pkg::XLEN-1:0]           data_mem_address_o,
    input logic [rv32i_pkg::XLEN-1:0]           data_mem_wdata_o,
    input logic                                 data_mem_resp_i,
    input logic                                 result_valid_o
);
    // read back by the testbench at the end of the run
    int fail_count = 0;

    // ack only answers a live request
    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else begin
            $error("ack_o rose without req_i");
            fail_count++;
        end

    // one strobe at a time, held until its response
    one_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((data_read_o || data_write_o) && !data_mem_resp_i) |=>
        ($onehot({data_read_o, data_write_o}) && $stable(data_read_o)))
        else begin
            $error("strobes both high or changed before the response");
            fail_count++;
        end

    // port fields frozen until the response edge
    port_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        ((data_read_o || data_write_o) && !data_mem_resp_i) |=>
        ($stable(data_mem_address_o) && $stable(data_mbe_o) && $stable(data_mem_wdata_o)))
        else begin
            $error("memory port changed while waiting");
            fail_count++;
        end

    result_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        result_valid_o |=> !result_valid_o)
        else begin
            $error("result_valid_o longer than one cycle");
            fail_count++;
        end

endmodule : lsu_sva

bind lsu_top lsu_sva u_lsu_sva (.*);

//--- tests/tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;
    import rv32i_pkg::*;
    import lsq_pkg::*;

    // 27 operations, worst case well under 75 cycles each
    localparam int MAX_CYCLES = 2000;

    logic                      clk;
    logic                      arst_n_i;
    logic                      req_i;
    logic                      ack_o;
    logic                      is_store_i;
    mem_funct3_u               funct3_i;
    logic [XLEN-1:0]           addr_i;
    logic [XLEN-1:0]           wdata_i;
    logic [TAG_WIDTH-1:0]      tag_i;
    logic                      data_read_o;
    logic                      data_write_o;
    logic [BYTES_PER_WORD-1:0] data_mbe_o;
    logic [XLEN-1:0]           data_mem_address_o;
    logic [XLEN-1:0]           data_mem_wdata_o;
    logic [XLEN-1:0]           data_mem_rdata_i;
    logic                      data_mem_resp_i;
    logic                      result_valid_o;
    logic [TAG_WIDTH-1:0]      result_tag_o;
    logic [XLEN-1:0]           result_data_o;

    logic [XLEN-1:0]           mem [16];
    integer                    seed;
    int                        stall_cycles;
    int                        resp_count;
    int                        cycles;
    int                        checks;
    int                        errors;

    // observed results and stores, oldest first
    logic [TAG_WIDTH-1:0]      res_tag_q [$];
    logic [XLEN-1:0]           res_data_q [$];
    logic [XLEN-1:0]           st_addr_q [$];
    logic [BYTES_PER_WORD-1:0] st_mbe_q [$];
    logic [XLEN-1:0]           st_data_q [$];

    lsu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] fill_word(input int unsigned idx);
        return (32'(idx) * 32'h9E37_79B9) ^ 32'h5A0F_C3E1;
    endfunction

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = fill_word(i);
        end
    end

    // answers each strobe after 1 to 3 cycles plus any stall
    initial begin : memory_model
        int          delay;
        int unsigned idx;
        forever begin
            @(negedge clk);
            if (arst_n_i && (data_read_o || data_write_o)) begin
                delay = 1 + ($unsigned($random(seed)) % 3) + stall_cycles;
                repeat (delay) @(posedge clk);
                #1;
                idx = data_mem_address_o[5:2];
                data_mem_rdata_i = mem[idx];
                data_mem_resp_i  = 1'b1;
                @(negedge clk);
                if (data_write_o) begin
                    for (int lane = 0; lane < BYTES_PER_WORD; lane++) begin
                        if (data_mbe_o[lane]) begin
                            mem[idx][lane*8 +: 8] = data_mem_wdata_o[lane*8 +: 8];
                        end
                    end
                    st_addr_q.push_back(data_mem_address_o);
                    st_mbe_q.push_back(data_mbe_o);
                    st_data_q.push_back(data_mem_wdata_o);
                end else if (data_mbe_o !== '0) begin
                    $display("FAIL t=%0t: load access with byte enables %b", $time, data_mbe_o);
                    errors++;
                end
                resp_count++;
                @(posedge clk);
                #1;
                data_mem_resp_i  = 1'b0;
                data_mem_rdata_i = '0;
            end
        end
    end

    always @(negedge clk) begin
        if (result_valid_o) begin
            res_tag_q.push_back(result_tag_o);
            res_data_q.push_back(result_data_o);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with tests unfinished", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // reference rules for lanes and extension
    function automatic logic [BYTES_PER_WORD-1:0] expected_mbe(input store_funct3_t t,
                                                               input logic [1:0] off);
        logic [BYTES_PER_WORD-1:0] mask;
        int                        size;
        int                        lane;
        mask = '0;
        size = (t == sw) ? 4 : ((t == sh) ? 2 : 1);
        for (lane = 0; lane < BYTES_PER_WORD; lane++) begin
            if (lane >= off && lane < off + size) begin
                mask[lane] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic logic [XLEN-1:0] expected_lanes(input logic [XLEN-1:0] wdata,
                                                       input logic [1:0] off);
        logic [XLEN-1:0] out;
        int              lane;
        out = '0;
        for (lane = 0; lane < BYTES_PER_WORD; lane++) begin
            if (lane >= off) begin
                out[lane*8 +: 8] = wdata[(lane - off)*8 +: 8];
            end
        end
        return out;
    endfunction

    function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] word,
                                                      input load_funct3_t t,
                                                      input logic [1:0] off);
        logic [XLEN-1:0] shifted;
        logic [XLEN-1:0] value;
        shifted = word >> (8 * off);
        case (t)
            lb, lbu: begin
                value = shifted & 32'h0000_00FF;
                if (t == lb && value[7]) value = value | 32'hFFFF_FF00;
            end
            lh, lhu: begin
                value = shifted & 32'h0000_FFFF;
                if (t == lh && value[15]) value = value | 32'hFFFF_0000;
            end
            default: value = word;
        endcase
        return value;
    endfunction

    task automatic check_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input logic [TAG_WIDTH-1:0] exp_tag,
                                input logic [XLEN-1:0] exp_word);
        logic [TAG_WIDTH-1:0] got_tag;
        logic [XLEN-1:0]      got_word;
        while (res_tag_q.size() == 0) @(negedge clk);
        got_tag  = res_tag_q.pop_front();
        got_word = res_data_q.pop_front();
        checks++;
        if (got_tag !== exp_tag || got_word !== exp_word) begin
            $display("FAIL t=%0t: load result tag %0d data %08h, expected tag %0d data %08h",
                     $time, got_tag, got_word, exp_tag, exp_word);
            errors++;
        end
    endtask

    task automatic check_store(input logic [XLEN-1:0] exp_addr,
                               input logic [BYTES_PER_WORD-1:0] exp_mbe,
                               input logic [XLEN-1:0] exp_word);
        logic [XLEN-1:0]           got_addr;
        logic [BYTES_PER_WORD-1:0] got_mbe;
        logic [XLEN-1:0]           got_word;
        while (st_addr_q.size() == 0) @(negedge clk);
        got_addr = st_addr_q.pop_front();
        got_mbe  = st_mbe_q.pop_front();
        got_word = st_data_q.pop_front();
        checks++;
        if (got_addr !== exp_addr || got_mbe !== exp_mbe || got_word !== exp_word) begin
            $display("FAIL t=%0t: store at %08h mbe %b data %08h, expected %08h mbe %b data %08h",
                     $time, got_addr, got_mbe, got_word, exp_addr, exp_mbe, exp_word);
            errors++;
        end
    endtask

    // full four-phase transfer of one operation
    task automatic send_op(input logic st, input mem_funct3_u f3, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata, input logic [TAG_WIDTH-1:0] tag);
        @(posedge clk);
        #1;
        is_store_i = st;
        funct3_i   = f3;
        addr_i     = addr;
        wdata_i    = wdata;
        tag_i      = tag;
        req_i      = 1'b1;
        while (!ack_o) @(negedge clk);
        @(posedge clk);
        #1;
        req_i = 1'b0;
        while (ack_o) @(negedge clk);
    endtask

    task automatic send_load(input load_funct3_t t, input logic [XLEN-1:0] addr,
                             input logic [TAG_WIDTH-1:0] tag);
        mem_funct3_u f;
        f.load = t;
        send_op(1'b0, f, addr, '0, tag);
    endtask

    task automatic send_store(input store_funct3_t t, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] wdata, input logic [TAG_WIDTH-1:0] tag);
        mem_funct3_u f;
        f.store = t;
        send_op(1'b1, f, addr, wdata, tag);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %-22s done, %0d errors", name, errors - errors_before);
    endtask

    task automatic reset_and_handshake();
        int          err_before;
        mem_funct3_u f;
        err_before = errors;
        @(negedge clk);
        check_level("ack_o after reset", ack_o, 1'b0);
        check_level("data_read_o after reset", data_read_o, 1'b0);
        check_level("data_write_o after reset", data_write_o, 1'b0);
        check_level("any data_mbe_o bit after reset", |data_mbe_o, 1'b0);
        check_level("result_valid_o after reset", result_valid_o, 1'b0);
        f.load = lw;
        @(posedge clk);
        #1;
        is_store_i = 1'b0;
        funct3_i   = f;
        addr_i     = 32'h0000_0004;
        tag_i      = 3'd5;
        req_i      = 1'b1;
        @(negedge clk);
        check_level("ack_o before the write edge", ack_o, 1'b0);
        @(negedge clk);
        check_level("ack_o one cycle after the write edge", ack_o, 1'b1);
        while (!ack_o) @(negedge clk);
        @(posedge clk);
        #1;
        req_i = 1'b0;
        @(negedge clk);
        check_level("ack_o right after req_i drop", ack_o, 1'b1);
        @(negedge clk);
        check_level("ack_o once req_i seen low", ack_o, 1'b0);
        check_result(3'd5, fill_word(1));
        report_test("reset_handshake", err_before);
    endtask

    task automatic store_then_load();
        int err_before;
        err_before = errors;
        send_store(sw, 32'h0000_0008, 32'h3C5A_96E1, 3'd1);
        send_load(lw, 32'h0000_0008, 3'd2);
        check_store(32'h0000_0008, 4'b1111, 32'h3C5A_96E1);
        check_result(3'd2, 32'h3C5A_96E1);
        report_test("store_then_load", err_before);
    endtask

    task automatic store_byte_lanes();
        int              err_before;
        int              off;
        logic [XLEN-1:0] wdata;
        err_before = errors;
        for (off = 0; off < BYTES_PER_WORD; off++) begin
            wdata = 32'h5A6B_7C8D ^ 32'(off);
            send_store(sb, 32'h0000_000C + 32'(off), wdata, 3'(off));
            check_store(32'h0000_000C, expected_mbe(sb, 2'(off)), expected_lanes(wdata, 2'(off)));
        end
        for (off = 0; off < BYTES_PER_WORD; off += 2) begin
            wdata = 32'hC1D2_E3F4 ^ 32'(off);
            send_store(sh, 32'h0000_000C + 32'(off), wdata, 3'(off));
            check_store(32'h0000_000C, expected_mbe(sh, 2'(off)), expected_lanes(wdata, 2'(off)));
        end
        report_test("store_lanes", err_before);
    endtask

    task automatic load_and_check(input load_funct3_t t, input logic [XLEN-1:0] word,
                                  input int off, inout logic [TAG_WIDTH-1:0] tag);
        tag = tag + 1'b1;
        send_load(t, 32'h0000_0010 + 32'(off), tag);
        check_result(tag, expected_load(word, t, 2'(off)));
    endtask

    task automatic load_sign_extension();
        int                   err_before;
        int                   off;
        logic [XLEN-1:0]      word;
        logic [TAG_WIDTH-1:0] tag;
        err_before = errors;
        // negative and positive bytes and halves
        word = 32'h7FE1_80C3;
        tag  = '0;
        send_store(sw, 32'h0000_0010, word, tag);
        check_store(32'h0000_0010, 4'b1111, word);
        for (off = 0; off < BYTES_PER_WORD; off++) begin
            load_and_check(lb, word, off, tag);
            load_and_check(lbu, word, off, tag);
        end
        for (off = 0; off < BYTES_PER_WORD; off += 2) begin
            load_and_check(lh, word, off, tag);
            load_and_check(lhu, word, off, tag);
        end
        report_test("load_extension", err_before);
    endtask

    task automatic queue_backpressure();
        int err_before;
        int resp_base;
        err_before   = errors;
        resp_base    = resp_count;
        stall_cycles = 30;
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            send_load(lw, 32'(8 + i) << 2, 3'(3 + i));
        end
        if (resp_count != resp_base) begin
            $display("memory answered before the queue filled, stall too short");
            errors++;
        end
        send_load(lw, 32'(8 + LSQ_DEPTH) << 2, 3'(3 + LSQ_DEPTH));
        if (resp_count == resp_base) begin
            $display("fifth operation was acknowledged while the queue was full");
            errors++;
        end
        stall_cycles = 0;
        for (int i = 0; i <= LSQ_DEPTH; i++) begin
            check_result(3'(3 + i), fill_word(8 + i));
        end
        report_test("backpressure_order", err_before);
    endtask

    initial begin
        seed             = 32'h4ac8_1499;
        stall_cycles     = 0;
        resp_count       = 0;
        cycles           = 0;
        checks           = 0;
        errors           = 0;
        arst_n_i         = 1'b0;
        req_i            = 1'b0;
        is_store_i       = 1'b0;
        funct3_i         = '0;
        addr_i           = '0;
        wdata_i          = '0;
        tag_i            = '0;
        data_mem_rdata_i = '0;
        data_mem_resp_i  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        reset_and_handshake();
        store_then_load();
        store_byte_lanes();
        load_sign_extension();
        queue_backpressure();

        repeat (5) @(posedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_lsu_sva.fail_count);
        if (errors == 0 && dut.u_lsu_sva.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_lsu

//--- compile.f
source/rv32i_pkg.sv
source/lsq_pkg.sv
source/lsq_entry_if.sv
source/lsq_fifo.sv
source/data_mem_ctrl.sv
source/load_formatter.sv
source/lsu_top.sv
tests/lsu_sva.sv
tests/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - source/rv32i_pkg.sv
  - source/lsq_pkg.sv
  - source/lsq_entry_if.sv
  - source/lsq_fifo.sv
  - source/data_mem_ctrl.sv
  - source/load_formatter.sv
  - source/lsu_top.sv
  - target: test
    files:
      - tests/lsu_sva.sv
      - tests/tb_lsu.sv
